// ==== flist.f ====
+incdir+logic
logic/mipsPkg.sv
logic/instrDecoder.sv
logic/pcUnit.sv
logic/regFile.sv
logic/alu.sv
logic/mipsCore.sv
verif/clockGen.sv
verif/mipsCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module mipsCoreTb -o simv \
  && ./obj_dir/simv 2>&1 | tee sim.log \
  || { echo "build or simulation error"; exit 1; }

grep -qF "** FAIL **" sim.log && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation clean"; exit 0; }

// ==== verif/mipsCoreTb.sv ====
// programs must fit in 64 instruction words and data in the 128-word memory, both answer at once
`include "mips_macros.svh"

module mipsCoreTb import mipsPkg::*; ();

  localparam int imemWords = 64;
  localparam int dmemWords = 1 << `DMEM_AW;
  // load, reset and program steps per test plus headroom
  localparam int cyclesPerTest = 20;
  localparam int numTests = 6;

  logic clk;
  logic rst;
  logic resetReq;
  logic loadReq;

  // dut ports
  logic [`DATA_W-1:0]  ir;
  logic [`DATA_W-1:0]  memRdata;
  logic [`DATA_W-1:0]  irAddr;
  logic [`DATA_W-1:0]  rfWriteData;
  logic [`DATA_W-1:0]  memWdata;
  logic [`DMEM_AW-1:0] memAddr;
  logic                memCen;
  logic                memWen;
  logic                rfWriteEn;

  // memories and the images they load from
  logic [`DATA_W-1:0] imem [imemWords] = '{default: '0};
  logic [`DATA_W-1:0] dmem [dmemWords] = '{default: '0};
  logic [`DATA_W-1:0] codeImage [imemWords];
  logic [`DATA_W-1:0] dataImage [dmemWords];

  integer seed;
  int     testErrs;
  int     passCount;
  int     failCount;
  string  testName;

  clockGen clockGen_inst (.resetReq(resetReq), .clk(clk), .rst(rst));

  mipsCore mipsCore_inst (
    .clk(clk), .rst(rst), .ir(ir), .memRdata(memRdata), .irAddr(irAddr),
    .rfWriteData(rfWriteData), .memWdata(memWdata), .memAddr(memAddr),
    .memCen(memCen), .memWen(memWen), .rfWriteEn(rfWriteEn)
  );

  // ==================================================
  // memory models
  // ==================================================

  // reads answer in the same cycle
  assign ir       = imem[irAddr[7:2]];
  assign memRdata = dmem[memAddr];

  // image load wins over a store
  always @(posedge clk) begin
    if (loadReq) begin
      for (int i = 0; i < imemWords; i++) begin
        imem[i] <= codeImage[i];
      end
      for (int i = 0; i < dmemWords; i++) begin
        dmem[i] <= dataImage[i];
      end
    end else if (!memCen && !memWen) begin
      dmem[memAddr] <= memWdata;
    end
  end

  // ==================================================
  // encoders and helpers
  // ==================================================

  function automatic logic [31:0] rInstr(functT f, logic [4:0] rs, rt, rd);
    return {rType, rs, rt, rd, 5'd0, f};
  endfunction

  function automatic logic [31:0] iInstr(opcodeT op, logic [4:0] rs, rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jInstr(opcodeT op, logic [25:0] target);
    return {op, target};
  endfunction

  // background data in which every address bit shows up
  function automatic logic [31:0] fillWord(int addr);
    return 32'hc0de0000 ^ (32'(addr) * 32'h00010003);
  endfunction

  task automatic showMismatch(string what, logic [31:0] expV, logic [31:0] actV);
    $display("ERR %s: %s expected %h actual %h", testName, what, expV, actV);
    testErrs++;
  endtask

  task automatic beginTest(string name);
    testName = name;
    testErrs = 0;
    for (int i = 0; i < imemWords; i++) begin
      codeImage[i] = '0;
    end
    for (int i = 0; i < dmemWords; i++) begin
      dataImage[i] = fillWord(i);
    end
  endtask

  task automatic endTest();
    if (testErrs == 0) begin
      $display("test %s passed", testName);
      passCount++;
    end else begin
      $display("test %s failed with %0d errors", testName, testErrs);
      failCount++;
    end
  endtask

  // step to the next instruction and sample it mid-cycle
  task automatic nextCycle();
    @(negedge clk);
  endtask

  // load images, hold reset, return with instruction 0 on ir
  task automatic startProgram();
    int lowCycles;
    @(posedge clk);
    resetReq <= 1'b1;
    loadReq  <= 1'b1;
    @(posedge clk);
    resetReq <= 1'b0;
    loadReq  <= 1'b0;
    @(negedge clk);
    lowCycles = 0;
    while (!rst) begin
      if (irAddr !== '0) showMismatch("irAddr in reset", '0, irAddr);
      if (memCen !== 1'b1) showMismatch("memCen in reset", 32'd1, 32'(memCen));
      if (memWen !== 1'b1) showMismatch("memWen in reset", 32'd1, 32'(memWen));
      if (rfWriteEn !== 1'b0) showMismatch("rfWriteEn in reset", '0, 32'(rfWriteEn));
      lowCycles++;
      @(negedge clk);
    end
    if (lowCycles != 5) showMismatch("reset cycles", 32'd5, 32'(lowCycles));
    if (irAddr !== '0) showMismatch("irAddr after reset", '0, irAddr);
  endtask

  // ==================================================
  // directed tests
  // ==================================================

  // sw at address 0 so the strobes would fire without the reset gate
  task automatic resetTest();
    beginTest("reset");
    codeImage[0] = iInstr(sw, 5'd0, 5'd0, 16'd0);
    startProgram();
    nextCycle();
    if (irAddr !== 32'd4) showMismatch("irAddr second cycle", 32'd4, irAddr);
    endTest();
  endtask

  task automatic rTypeTest();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expVal [8];
    string       stepName [8];
    // opposite signs so signed and unsigned slt disagree
    a = $random(seed) | 32'h8000_0000;
    b = $random(seed) & 32'h7fff_ffff;
    beginTest("rtype");
    dataImage[0] = a;
    dataImage[1] = b;
    codeImage[0] = iInstr(lw, 5'd0, 5'd1, 16'd0);
    codeImage[1] = iInstr(lw, 5'd0, 5'd2, 16'd4);
    codeImage[2] = rInstr(fAdd, 5'd1, 5'd2, 5'd3);
    codeImage[3] = rInstr(fSub, 5'd1, 5'd2, 5'd4);
    codeImage[4] = rInstr(fAnd, 5'd1, 5'd2, 5'd5);
    codeImage[5] = rInstr(fOr, 5'd1, 5'd2, 5'd6);
    codeImage[6] = rInstr(fSlt, 5'd1, 5'd2, 5'd7);
    codeImage[7] = rInstr(fSlt, 5'd2, 5'd1, 5'd8);
    expVal = '{a, b, a + b, a - b, a & b, a | b,
               ($signed(a) < $signed(b)) ? 32'd1 : 32'd0,
               ($signed(b) < $signed(a)) ? 32'd1 : 32'd0};
    stepName = '{"lw r1", "lw r2", "add", "sub", "and", "or", "slt ab", "slt ba"};
    startProgram();
    for (int k = 0; k < 8; k++) begin
      if (rfWriteData !== expVal[k]) showMismatch(stepName[k], expVal[k], rfWriteData);
      if (rfWriteEn !== 1'b1) showMismatch({stepName[k], " wen"}, 32'd1, 32'(rfWriteEn));
      nextCycle();
    end
    endTest();
  endtask

  task automatic loadStoreTest();
    logic [31:0] v;
    v = $random(seed);
    beginTest("loadstore");
    dataImage[2] = v;
    codeImage[0] = iInstr(lw, 5'd0, 5'd1, 16'd8);
    codeImage[1] = iInstr(sw, 5'd0, 5'd1, 16'd20);
    codeImage[2] = iInstr(lw, 5'd0, 5'd2, 16'd20);
    startProgram();
    if (memWen !== 1'b1) showMismatch("memWen on lw", 32'd1, 32'(memWen));
    if (memCen !== 1'b0) showMismatch("memCen on lw", '0, 32'(memCen));
    nextCycle();
    // byte offset 20 is word 5
    if (memWen !== 1'b0) showMismatch("memWen on sw", '0, 32'(memWen));
    if (memAddr !== 7'd5) showMismatch("memAddr on sw", 32'd5, 32'(memAddr));
    if (memWdata !== v) showMismatch("memWdata on sw", v, memWdata);
    nextCycle();
    if (memWen !== 1'b1) showMismatch("memWen on reload", 32'd1, 32'(memWen));
    if (dmem[5] !== v) showMismatch("stored word", v, dmem[5]);
    if (rfWriteData !== v) showMismatch("reloaded word", v, rfWriteData);
    endTest();
  endtask

  task automatic branchTest();
    logic [31:0] x;
    x = $random(seed);
    beginTest("branch");
    dataImage[0] = x;
    dataImage[1] = x;
    dataImage[2] = x ^ 32'h1;
    codeImage[0] = iInstr(lw, 5'd0, 5'd1, 16'd0);
    codeImage[1] = iInstr(lw, 5'd0, 5'd2, 16'd4);
    codeImage[2] = iInstr(lw, 5'd0, 5'd3, 16'd8);
    codeImage[3] = iInstr(beq, 5'd1, 5'd2, 16'd3);
    codeImage[7] = iInstr(beq, 5'd1, 5'd3, 16'd5);
    // backward branch with offset -8
    codeImage[8] = iInstr(beq, 5'd0, 5'd0, 16'hfff8);
    startProgram();
    nextCycle();
    nextCycle();
    nextCycle();
    if (irAddr !== 32'd12) showMismatch("beq fetch", 32'd12, irAddr);
    nextCycle();
    if (irAddr !== 32'(12 + 4 + 3 * 4)) showMismatch("taken", 32'(12 + 4 + 3 * 4), irAddr);
    nextCycle();
    if (irAddr !== 32'(28 + 4)) showMismatch("not taken", 32'(28 + 4), irAddr);
    nextCycle();
    if (irAddr !== 32'(32 + 4 - 8 * 4)) showMismatch("backward", 32'(32 + 4 - 8 * 4), irAddr);
    endTest();
  endtask

  task automatic jumpTest();
    beginTest("jump");
    codeImage[0]  = jInstr(j, 26'd5);
    codeImage[5]  = jInstr(jal, 26'd10);
    codeImage[10] = iInstr(sw, 5'd0, 5'd31, 16'd12);
    startProgram();
    if (rfWriteEn !== 1'b0) showMismatch("j wen", '0, 32'(rfWriteEn));
    nextCycle();
    // pc+4 high nibble is zero this low in memory
    if (irAddr !== {4'h0, 26'd5, 2'b00}) showMismatch("j target", {4'h0, 26'd5, 2'b00}, irAddr);
    if (rfWriteData !== 32'd24) showMismatch("jal link", 32'd24, rfWriteData);
    if (rfWriteEn !== 1'b1) showMismatch("jal wen", 32'd1, 32'(rfWriteEn));
    nextCycle();
    if (irAddr !== {4'h0, 26'd10, 2'b00}) showMismatch("jal target", 32'd40, irAddr);
    if (memWdata !== 32'd24) showMismatch("sw r31 data", 32'd24, memWdata);
    nextCycle();
    if (dmem[3] !== 32'd24) showMismatch("stored link", 32'd24, dmem[3]);
    endTest();
  endtask

  task automatic zeroRegTest();
    logic [31:0] v;
    v = $random(seed) | 32'h1;
    beginTest("zeroreg");
    dataImage[0] = v;
    codeImage[0] = iInstr(lw, 5'd0, 5'd1, 16'd0);
    codeImage[1] = rInstr(fAdd, 5'd1, 5'd1, 5'd0);
    codeImage[2] = iInstr(sw, 5'd0, 5'd0, 16'd16);
    startProgram();
    nextCycle();
    if (rfWriteEn !== 1'b0) showMismatch("add r0 wen", '0, 32'(rfWriteEn));
    nextCycle();
    if (memWdata !== '0) showMismatch("sw r0 data", '0, memWdata);
    nextCycle();
    if (dmem[4] !== '0) showMismatch("stored r0", '0, dmem[4]);
    endTest();
  endtask

  // ==================================================
  // sequence, summary and watchdog
  // ==================================================

  initial begin
    seed      = 96527;
    resetReq  = 1'b0;
    loadReq   = 1'b0;
    passCount = 0;
    failCount = 0;
    resetTest();
    rTypeTest();
    loadStoreTest();
    branchTest();
    jumpTest();
    zeroRegTest();
    $display("tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(numTests * cyclesPerTest * 100 + 1000);
    $display("watchdog expired, the tests did not finish in the expected time");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== verif/clockGen.sv ====
// free-running clock of period 100, rst low for 5 cycles after power-up and after each request
module clockGen (
  input  logic resetReq,
  output logic clk,
  output logic rst
);

  // cycles of reset still to go
  int lowLeft = 5;

  always begin
    clk = 1'b0;
    #50;
    clk = 1'b1;
    #50;
  end

  // request seen on an edge restarts the 5-cycle window
  always @(posedge clk) begin
    if (resetReq) begin
      lowLeft <= 5;
    end else if (lowLeft != 0) begin
      lowLeft <= lowLeft - 1;
    end
  end

  assign rst = (lowLeft == 0);

endmodule

// ==== logic/mipsCore.sv ====
// single-cycle core, memories outside, both memories must answer within the same cycle
`include "mips_macros.svh"

module mipsCore import mipsPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [`DATA_W-1:0]  ir,
  input  logic [`DATA_W-1:0]  memRdata,
  output logic [`DATA_W-1:0]  irAddr,
  output logic [`DATA_W-1:0]  rfWriteData,
  output logic [`DATA_W-1:0]  memWdata,
  output logic [`DMEM_AW-1:0] memAddr,
  output logic                memCen,
  output logic                memWen,
  output logic                rfWriteEn
);

  // instruction fields
  opcodeT                opcode;
  functT                 funct;
  logic [`REG_ADDR_W-1:0] rs;
  logic [`REG_ADDR_W-1:0] rt;
  logic [`REG_ADDR_W-1:0] rd;
  logic [15:0]           imm;
  logic [`DATA_W-1:0]    signExt;

  // decoder controls
  logic  regDst;
  logic  aluSrc;
  logic  memToReg;
  logic  regWrite;
  logic  memWrite;
  logic  memRead;
  logic  jump;
  logic  link;
  logic  branch;
  aluOpT aluOp;

  // datapath
  logic [`REG_ADDR_W-1:0] writeAddr;
  logic [`DATA_W-1:0]     readData1;
  logic [`DATA_W-1:0]     readData2;
  logic [`DATA_W-1:0]     aluB;
  logic [`DATA_W-1:0]     aluResult;
  logic                   aluZero;
  logic [`DATA_W-1:0]     pc;
  logic [`DATA_W-1:0]     pcPlus4;

  // ==================================================
  // field split and immediate
  // ==================================================

  assign opcode  = opcodeT'(ir[31:26]);
  assign funct   = functT'(ir[5:0]);
  assign rs      = ir[25:21];
  assign rt      = ir[20:16];
  assign rd      = ir[15:11];
  assign imm     = ir[15:0];
  assign signExt = {{(`DATA_W-16){imm[15]}}, imm};

  instrDecoder instrDecoder_inst (
    .rst(rst), .opcode(opcode), .funct(funct),
    .regDst(regDst), .aluSrc(aluSrc), .memToReg(memToReg), .regWrite(regWrite),
    .memWrite(memWrite), .memRead(memRead), .jump(jump), .link(link),
    .branch(branch), .aluOp(aluOp)
  );

  // ==================================================
  // register file and alu
  // ==================================================

  // jal targets r31, r-type rd, loads rt
  assign writeAddr = link   ? `REG_ADDR_W'(`REG_COUNT - 1) :
                     regDst ? rd : rt;

  regFile regFile_inst (
    .clk(clk), .rst(rst), .writeEn(regWrite),
    .readAddr1(rs), .readAddr2(rt), .writeAddr(writeAddr), .writeData(rfWriteData),
    .readData1(readData1), .readData2(readData2)
  );

  // immediate for lw and sw address
  assign aluB = aluSrc ? signExt : readData2;

  alu alu_inst (
    .a(readData1), .b(aluB), .op(aluOp), .result(aluResult), .zero(aluZero)
  );

  // write-back select, link wins over load
  assign rfWriteData = link     ? pcPlus4  :
                       memToReg ? memRdata : aluResult;

  // r0 writes are dropped inside regFile
  assign rfWriteEn = regWrite && (writeAddr != '0);

  // ==================================================
  // program counter and memory ports
  // ==================================================

  pcUnit pcUnit_inst (
    .clk(clk), .rst(rst), .jump(jump), .taken(branch && aluZero),
    .jumpTarget(ir[25:0]), .branchOffset(signExt), .pc(pc), .pcPlus4(pcPlus4)
  );

  assign irAddr = pc;

  // byte address to word index
  assign memAddr  = aluResult[`DMEM_AW+1:2];
  assign memWdata = readData2;

  // active low strobes
  assign memCen = !(memRead || memWrite);
  assign memWen = !memWrite;

endmodule

// ==== logic/alu.sv ====
// combinational, slt compares signed, no overflow detection
`include "mips_macros.svh"

module alu import mipsPkg::*; (
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  aluOpT              op,
  output logic [`DATA_W-1:0] result,
  output logic               zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = ($signed(a) < $signed(b));

  // ==================================================
  // operation select
  // ==================================================

  always_comb begin
    case (op)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // single bit result, zero extended
      aluSlt: result = {{(`DATA_W-1){1'b0}}, lessThan};
      default: result = '0;
    endcase
  end

  // beq uses this after subtract
  assign zero = (result == '0);

endmodule

// ==== logic/regFile.sv ====
// reads are combinational, write lands on the rising edge, register 0 is never written
`include "mips_macros.svh"

module regFile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  writeEn,
  input  logic [`REG_ADDR_W-1:0] readAddr1,
  input  logic [`REG_ADDR_W-1:0] readAddr2,
  input  logic [`REG_ADDR_W-1:0] writeAddr,
  input  logic [`DATA_W-1:0]     writeData,
  output logic [`DATA_W-1:0]     readData1,
  output logic [`DATA_W-1:0]     readData2
);

  logic [`DATA_W-1:0] regs [`REG_COUNT];

  // ==================================================
  // write port
  // ==================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // r0 stays at its reset value
      regs[writeAddr] <= writeData;
    end
  end

  // ==================================================
  // read ports
  // ==================================================

  // straight array reads, r0 zero comes from reset
  // plus the write guard above
  assign readData1 = regs[readAddr1];
  assign readData2 = regs[readAddr2];

  // r0 must read as zero after any write history
  assert property (@(posedge clk) disable iff (!rst)
    (readAddr1 == '0) |-> (readData1 == '0));

  assert property (@(posedge clk) disable iff (!rst)
    (readAddr2 == '0) |-> (readData2 == '0));

endmodule

// ==== logic/pcUnit.sv ====
// jump keeps the high nibble of pc+4, no delay slot, pc clears to zero on reset
`include "mips_macros.svh"

module pcUnit (
  input  logic               clk,
  input  logic               rst,
  input  logic               jump,
  input  logic               taken,
  input  logic [25:0]        jumpTarget,
  input  logic [`DATA_W-1:0] branchOffset,
  output logic [`DATA_W-1:0] pc,
  output logic [`DATA_W-1:0] pcPlus4
);

  logic [`DATA_W-1:0] nextPc;
  logic [`DATA_W-1:0] jumpAddr;
  logic [`DATA_W-1:0] branchAddr;

  // ==================================================
  // next address
  // ==================================================

  assign pcPlus4 = pc + `DATA_W'd4;

  // pseudo-direct target, word aligned
  assign jumpAddr = {pcPlus4[`DATA_W-1 -: 4], jumpTarget, 2'b00};

  // offset counts words
  assign branchAddr = pcPlus4 + (branchOffset << 2);

  always_comb begin
    if (jump) begin
      nextPc = jumpAddr;
    end else if (taken) begin
      nextPc = branchAddr;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // ==================================================
  // pc register
  // ==================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  // fetch address stays word aligned for all paths
  assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00);

endmodule

// ==== logic/instrDecoder.sv ====
// combinational decoder that gives no writes or strobes for unknown codes or while rst is low
module instrDecoder import mipsPkg::*; (
  input  logic   rst,
  input  opcodeT opcode,
  input  functT  funct,
  output logic   regDst,
  output logic   aluSrc,
  output logic   memToReg,
  output logic   regWrite,
  output logic   memWrite,
  output logic   memRead,
  output logic   jump,
  output logic   link,
  output logic   branch,
  output aluOpT  aluOp
);

  always_comb begin
    // idle defaults with nothing written and no memory access
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    memRead  = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    branch   = 1'b0;
    aluOp    = aluNone;

    // no valid fetch while in reset
    if (rst) begin
      case (opcode)
        rType: begin
          regDst = 1'b1;
          // function code picks the alu op
          case (funct)
            fAdd: aluOp = aluAdd;
            fSub: aluOp = aluSub;
            fAnd: aluOp = aluAnd;
            fOr:  aluOp = aluOr;
            fSlt: aluOp = aluSlt;
            default: aluOp = aluNone;
          endcase
          // unknown funct writes nothing
          regWrite = (aluOp != aluNone);
        end
        lw: begin
          aluSrc   = 1'b1;
          memToReg = 1'b1;
          regWrite = 1'b1;
          memRead  = 1'b1;
          aluOp    = aluAdd;
        end
        sw: begin
          aluSrc   = 1'b1;
          memWrite = 1'b1;
          aluOp    = aluAdd;
        end
        // equality via subtract and zero flag
        beq: begin
          branch = 1'b1;
          aluOp  = aluSub;
        end
        j: jump = 1'b1;
        // return address goes to r31
        jal: begin
          jump     = 1'b1;
          link     = 1'b1;
          regWrite = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== logic/mipsPkg.sv ====
// encodings cover only the supported subset, anything else decodes as an unknown instruction
package mipsPkg;

  // ==================================================
  // instruction opcodes, ir[31:26]
  // ==================================================
  typedef enum logic [5:0] {
    rType = 6'h00,
    j     = 6'h02,
    jal   = 6'h03,
    beq   = 6'h04,
    lw    = 6'h23,
    sw    = 6'h2b
  } opcodeT;

  // ==================================================
  // r-type function codes, ir[5:0]
  // ==================================================
  typedef enum logic [5:0] {
    fAdd = 6'h20,
    fSub = 6'h22,
    fAnd = 6'h24,
    fOr  = 6'h25,
    fSlt = 6'h2a
  } functT;

  // ==================================================
  // alu operations
  // ==================================================
  // aluNone drives a zero result
  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluSlt  = 3'd4,
    aluNone = 3'd7
  } aluOpT;

endpackage

// ==== logic/mips_macros.svh ====
// widths assume a 32-bit core, 32 registers and a 128-word data memory addressed by word
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// ==================================================
// datapath
// ==================================================

// word width of registers, alu and pc
`define DATA_W 32

// ==================================================
// register file
// ==================================================

`define REG_COUNT 32
// index width for REG_COUNT entries
`define REG_ADDR_W 5

// ==================================================
// data memory
// ==================================================

// word address, 128 words
`define DMEM_AW 7

`endif
